/* bench/hbus_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Watches reset behavior and every Wishbone answer of the controller.
// Expectations arrive from the stimulus loop while a cycle is open.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hbus_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_ack_i,
    input  logic               wb_err_i,
    input  hbus_pkg::hb_word_t wb_dat_i,
    input  logic               hbus_clk_i,
    input  logic               hbus_csn_i,
    input  logic               hbus_rstn_i,
    input  logic               exp_valid_i,
    input  logic               exp_read_i,
    input  logic               exp_err_i,
    input  hbus_pkg::hb_word_t exp_dat_i,
    input  int                 entry_i,
    output int                 pass_cnt_o,
    output int                 fail_cnt_o
);

    import hbus_pkg::*;

    task automatic expect_bit(input string name, input logic want, input logic got,
                              inout int errs);
        if (got !== want) begin
            $display("FAILED %s expected %h got %h", name, want, got);
            errs++;
        end
    endtask

    task automatic finish_test(input string what, input int errs);
        if (errs == 0) begin
            $display("%s: ok", what);
            pass_cnt_o++;
        end else begin
            $display("%s: %0d mismatches", what, errs);
            fail_cnt_o++;
        end
    endtask

    task automatic check_answer();
        int errs;
        errs = 0;
        if (!exp_valid_i) begin
            $display("Controller answered while no Wishbone cycle was open");
            fail_cnt_o++;
        end else if (wb_ack_i === 1'b1 && wb_err_i === 1'b1) begin
            $display("Entry %0d got ack and err in the same clock", entry_i);
            fail_cnt_o++;
        end else begin
            expect_bit("wb_err_o", exp_err_i, wb_err_i, errs);
            if (exp_read_i && !exp_err_i && wb_dat_i !== exp_dat_i) begin
                $display("FAILED wb_dat_o expected %h got %h", exp_dat_i, wb_dat_i);
                errs++;
            end
            finish_test($sformatf("entry %0d %s", entry_i, exp_read_i ? "read" : "write"),
                        errs);
        end
    endtask

    // clk90 is high at every clk falling edge, so hbus_clk shows its enable here
    initial begin : watch
        int errs;
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        errs       = 0;
        @(negedge clk);
        expect_bit("hbus_csn_o", 1'b1, hbus_csn_i, errs);
        expect_bit("hbus_rstn_o", 1'b0, hbus_rstn_i, errs);
        expect_bit("hbus_clk_o", 1'b0, hbus_clk_i, errs);
        @(negedge rst);
        // Device reset stays low for RESET_COUNT+1 clocks after release
        for (int k = 0; k <= RESET_COUNT; k++) begin
            @(negedge clk);
            expect_bit("hbus_rstn_o", 1'b0, hbus_rstn_i, errs);
            expect_bit("hbus_csn_o", 1'b1, hbus_csn_i, errs);
            expect_bit("hbus_clk_o", 1'b0, hbus_clk_i, errs);
            expect_bit("wb_ack_o", 1'b0, wb_ack_i, errs);
            expect_bit("wb_err_o", 1'b0, wb_err_i, errs);
        end
        @(negedge clk);
        expect_bit("hbus_rstn_o", 1'b1, hbus_rstn_i, errs);
        expect_bit("hbus_csn_o", 1'b1, hbus_csn_i, errs);
        expect_bit("hbus_clk_o", 1'b0, hbus_clk_i, errs);
        finish_test("reset", errs);
        forever begin
            @(negedge clk);
            if (wb_ack_i === 1'b1 || wb_err_i === 1'b1) begin
                check_answer();
            end
        end
    end

endmodule

/* bench/hbus_ram_model.sv */
////////////////////////////////////////////////////////////////////////////
// Behavioral HyperRAM, 64 words, single-word linear accesses only.
// Latency choice follows long_lat_i and is shown on RWDS while deselected,
// because the controller samples RWDS from the first command clock on.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hbus_ram_model (
    input  logic       hbus_clk_i,
    input  logic       hbus_csn_i,
    input  logic       hbus_rstn_i,
    input  logic       long_lat_i,
    inout  wire  [7:0] dq_io,
    inout  wire        rwds_io
);

    import hbus_pkg::*;

    localparam int          MEM_WORDS  = 64;
    localparam logic [15:0] ID_VALUE   = 16'h0C81;
    localparam logic [30:0] SILENT_REG = 31'h1F;

    logic [15:0] mem [MEM_WORDS];
    logic [47:0] ca;
    logic [30:0] addr;
    logic [15:0] rd_word;
    logic        rd_valid;
    logic [7:0]  dq_drv;
    logic        dq_en;
    logic        rwds_drv;
    logic        rwds_en;
    logic [7:0]  wr_hi;
    logic        wr_mask_hi;
    int          edge_cnt;
    int          rd_edge;
    int          wr_edge;

    assign dq_io   = dq_en ? dq_drv : 8'bz;
    assign rwds_io = hbus_csn_i ? long_lat_i : (rwds_en ? rwds_drv : 1'bz);

    // Fill pattern uses every address bit
    function automatic logic [15:0] fill_word(input logic [5:0] a);
        return {2'b01, a, 2'b10, ~a};
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(6'(i));
        end
        dq_en    = 1'b0;
        rwds_en  = 1'b0;
        edge_cnt = 0;
    end

    always @(posedge hbus_csn_i or negedge hbus_rstn_i) begin
        dq_en   = 1'b0;
        rwds_en = 1'b0;
    end

    // Keep the latency level on RWDS through the command
    always @(negedge hbus_csn_i) begin
        edge_cnt = 0;
        rwds_drv = long_lat_i;
        rwds_en  = 1'b1;
        rd_edge  = 2 + (long_lat_i ? 2 * TACC_COUNT : TACC_COUNT);
        wr_edge  = rd_edge + 2;
    end

    always @(posedge hbus_clk_i) begin
        if (!hbus_csn_i) begin
            edge_cnt = edge_cnt + 1;
            case (edge_cnt)
                1: ca[47:40] = dq_io;
                2: ca[31:24] = dq_io;
                3: ca[15:8]  = dq_io;
                default: ;
            endcase
            // Second byte goes out with the RWDS rise
            if (ca[47] && rd_valid && edge_cnt == rd_edge) begin
                dq_drv   = rd_word[7:0];
                rwds_drv = 1'b1;
            end
            if (!ca[47] && edge_cnt == wr_edge) begin
                wr_hi      = dq_io;
                wr_mask_hi = rwds_io;
            end
        end
    end

    always @(negedge hbus_clk_i) begin
        if (!hbus_csn_i) begin
            case (edge_cnt)
                1: ca[39:32] = dq_io;
                2: ca[23:16] = dq_io;
                3: begin
                    ca[7:0] = dq_io;
                    addr    = {ca[43:16], ca[2:0]};
                    if (ca[47]) begin
                        rwds_drv = 1'b0;
                        if (ca[46]) begin
                            rd_valid = (addr != SILENT_REG);
                            rd_word  = (addr == '0) ? ID_VALUE : 16'h0000;
                        end else begin
                            rd_valid = 1'b1;
                            rd_word  = mem[addr[5:0]];
                        end
                    end else begin
                        // Controller owns RWDS as the write mask
                        rwds_en = 1'b0;
                    end
                end
                default: ;
            endcase
            if (ca[47] && rd_valid && edge_cnt == rd_edge - 1) begin
                dq_en    = 1'b1;
                dq_drv   = rd_word[15:8];
                rwds_drv = 1'b0;
            end
            if (ca[47] && edge_cnt == rd_edge) begin
                dq_en   = 1'b0;
                rwds_en = 1'b0;
            end
            if (!ca[47] && !ca[46] && edge_cnt == wr_edge) begin
                if (!wr_mask_hi) begin
                    mem[addr[5:0]][15:8] = wr_hi;
                end
                if (!rwds_io) begin
                    mem[addr[5:0]][7:0] = dq_io;
                end
            end
        end
    end

endmodule

/* bench/tb_hbus.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for hbus_top with a behavioral HyperRAM on the pins.
// Error entries must stay last since the controller error state is sticky.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_hbus;

    import hbus_pkg::*;

    localparam int NUM_ENTRIES    = 14;
    localparam int CLK_PERIOD     = 100;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40 + 50;

    typedef struct packed {
        logic        we;
        logic [31:0] adr;
        hb_word_t    dat;
        logic [1:0]  sel;
        hb_word_t    exp_dat;
        logic        exp_err;
    } stim_t;

    logic        clk;
    logic        clk90;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    hb_word_t    wb_dat_w;
    logic [1:0]  wb_sel;
    hb_word_t    wb_dat_r;
    logic        wb_ack;
    logic        wb_err;
    logic        hbus_clk;
    logic        hbus_csn;
    logic        hbus_rstn;
    wire  [7:0]  hbus_dq;
    wire         hbus_rwds;

    logic        exp_valid;
    logic        exp_read;
    logic        exp_err;
    hb_word_t    exp_dat;
    int          entry_idx;
    int          pass_cnt;
    int          fail_cnt;

    stim_t       stim_tbl [NUM_ENTRIES];
    hb_word_t    shadow [64];
    int          n_entries;
    logic        in_error;
    integer      seed;
    int          cycle_count = 0;

    hbus_top i_hbus_top (
        .clk          (clk),
        .clk90        (clk90),
        .rst          (rst),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_w),
        .wb_sel_i     (wb_sel),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack),
        .wb_err_o     (wb_err),
        .hbus_clk_o   (hbus_clk),
        .hbus_csn_o   (hbus_csn),
        .hbus_rstn_o  (hbus_rstn),
        .hbus_dq_io   (hbus_dq),
        .hbus_rwds_io (hbus_rwds)
    );

    hbus_ram_model i_ram (
        .hbus_clk_i  (hbus_clk),
        .hbus_csn_i  (hbus_csn),
        .hbus_rstn_i (hbus_rstn),
        .long_lat_i  (wb_adr[4]),
        .dq_io       (hbus_dq),
        .rwds_io     (hbus_rwds)
    );

    hbus_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .wb_ack_i    (wb_ack),
        .wb_err_i    (wb_err),
        .wb_dat_i    (wb_dat_r),
        .hbus_clk_i  (hbus_clk),
        .hbus_csn_i  (hbus_csn),
        .hbus_rstn_i (hbus_rstn),
        .exp_valid_i (exp_valid),
        .exp_read_i  (exp_read),
        .exp_err_i   (exp_err),
        .exp_dat_i   (exp_dat),
        .entry_i     (entry_idx),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Quarter period behind clk
    initial begin
        clk90 = 1'b0;
        #(CLK_PERIOD / 4);
        forever #(CLK_PERIOD / 2) clk90 = ~clk90;
    end

    function automatic hb_word_t next_word();
        int r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic add_write(input logic [30:0] addr, input hb_word_t data,
                             input logic [1:0] sel);
        stim_t s;
        s         = '0;
        s.we      = 1'b1;
        s.adr     = {1'b0, addr};
        s.dat     = data;
        s.sel     = sel;
        s.exp_err = in_error;
        // Only enabled bytes reach the memory
        if (!in_error && sel[1]) begin
            shadow[addr[5:0]].first = data.first;
        end
        if (!in_error && sel[0]) begin
            shadow[addr[5:0]].second = data.second;
        end
        stim_tbl[n_entries] = s;
        n_entries++;
    endtask

    task automatic add_read(input logic [31:0] adr, input hb_word_t want,
                            input logic silent);
        stim_t s;
        s         = '0;
        s.adr     = adr;
        s.sel     = 2'b11;
        s.exp_dat = want;
        s.exp_err = in_error | silent;
        if (silent) begin
            in_error = 1'b1;
        end
        stim_tbl[n_entries] = s;
        n_entries++;
    endtask

    task automatic run_entry(input int idx);
        stim_t s;
        s = stim_tbl[idx];
        @(posedge clk);
        #5;
        entry_idx = idx;
        exp_read  = ~s.we;
        exp_err   = s.exp_err;
        exp_dat   = s.exp_dat;
        exp_valid = 1'b1;
        wb_we     = s.we;
        wb_adr    = s.adr;
        wb_dat_w  = s.dat;
        wb_sel    = s.sel;
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        do begin
            @(negedge clk);
        end while (!(wb_ack || wb_err));
        @(posedge clk);
        #5;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        exp_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        wb_sel    = 2'b00;
        exp_valid = 1'b0;
        exp_read  = 1'b0;
        exp_err   = 1'b0;
        exp_dat   = '0;
        entry_idx = 0;
        n_entries = 0;
        in_error  = 1'b0;
        seed      = 32'h4bdd;

        // Full write then partial writes, at 1x and 2x latency addresses
        add_write(31'h02, next_word(), 2'b11);
        add_read(32'h0000_0002, shadow[6'h02], 1'b0);
        add_write(31'h02, next_word(), 2'b01);
        add_read(32'h0000_0002, shadow[6'h02], 1'b0);
        add_write(31'h13, next_word(), 2'b11);
        add_read(32'h0000_0013, shadow[6'h13], 1'b0);
        add_write(31'h13, next_word(), 2'b10);
        add_read(32'h0000_0013, shadow[6'h13], 1'b0);
        add_write(31'h05, next_word(), 2'b11);
        add_read(32'h0000_0005, shadow[6'h05], 1'b0);
        add_read(32'h8000_0000, 16'h0C81, 1'b0);
        add_read(32'h8000_001F, 16'h0000, 1'b1);
        add_read(32'h0000_0002, shadow[6'h02], 1'b0);
        add_write(31'h13, next_word(), 2'b11);

        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        repeat (2) @(posedge clk);

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == NUM_ENTRIES + 1) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
design/hbus_pkg.sv
design/hbus_wb_slave.sv
design/hbus_sequencer.sv
design/hbus_ddr_io.sv
design/hbus_top.sv
bench/hbus_ram_model.sv
bench/hbus_checker.sv
bench/tb_hbus.sv

/* design/hbus_ddr_io.sv */
////////////////////////////////////////////////////////////////////////////
// Behavioral DDR pad, not a vendor primitive; the output mux uses clk
// as data. Outputs appear one clk after dat_i, inputs two clk later.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hbus_ddr_io #(
    parameter type word_t = hbus_pkg::hb_word_t
) (
    input  logic                        clk,
    input  logic                        rst,
    input  word_t                       dat_i,
    output word_t                       dat_o,
    input  logic                        oe_i,
    inout  wire [$bits(word_t)/2-1:0]   pad_io
);

    localparam int HALF_W = $bits(word_t) / 2;

    logic [2*HALF_W-1:0] out_q;
    logic                oe_q;
    logic [HALF_W-1:0]   rise_q;
    logic [HALF_W-1:0]   fall_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            oe_q <= 1'b0;
        end else begin
            oe_q <= oe_i;
        end
    end

    always_ff @(posedge clk) begin
        out_q <= dat_i;
    end

    // Upper half while clk is high, lower half while low
    assign pad_io = oe_q ? (clk ? out_q[2*HALF_W-1:HALF_W] : out_q[HALF_W-1:0])
                         : 'z;

    always_ff @(negedge clk) begin
        fall_q <= pad_io;
    end

    // Rising sample is the earlier phase of the pair
    always_ff @(posedge clk) begin
        rise_q <= pad_io;
        dat_o  <= {rise_q, fall_q};
    end

endmodule

/* design/hbus_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared constants and types for the single-device HyperBus controller.
// Only 8-bit DQ is supported; the first DDR phase sits in the upper half.
// Counter width covers both the read timeout and the 2x latency count.
////////////////////////////////////////////////////////////////////////////

package hbus_pkg;

    // Bus widths
    localparam int HB_WIDTH      = 8;
    localparam int HB_WORD_WIDTH = 2 * HB_WIDTH;
    localparam int HB_CA_WIDTH   = 3 * HB_WORD_WIDTH;
    localparam int HB_ADDR_WIDTH = 31;

    // Timing in clk cycles
    localparam int TACC_COUNT    = 5;
    localparam int RESET_COUNT   = 2;
    localparam int READ_TIMEOUT  = 15;
    localparam int CS_IDLE_COUNT = 2;

    localparam int CNT_MAX   = (READ_TIMEOUT > 2 * TACC_COUNT) ? READ_TIMEOUT
                                                               : 2 * TACC_COUNT;
    localparam int CNT_WIDTH = $clog2(CNT_MAX + 1);

    // One DDR word, both phases
    typedef struct packed {
        logic [HB_WIDTH-1:0] first;
        logic [HB_WIDTH-1:0] second;
    } hb_word_t;

    typedef struct packed {
        logic first;
        logic second;
    } hb_rwds_t;

    // Request from the Wishbone side, mask bit set means byte not written
    typedef struct packed {
        logic                     write;
        logic                     reg_space;
        logic [HB_ADDR_WIDTH-1:0] addr;
        hb_word_t                 wdata;
        logic [1:0]               mask;
    } hb_req_t;

    typedef struct packed {
        logic     done;
        logic     error;
        hb_word_t rdata;
    } hb_rsp_t;

    typedef enum logic [6:0] {
        IDLE    = 7'b0000001,
        RESET   = 7'b0000010,
        COMMAND = 7'b0000100,
        LATENCY = 7'b0001000,
        READ    = 7'b0010000,
        WRITE   = 7'b0100000,
        ERROR   = 7'b1000000
    } hb_state_t;

endpackage

/* design/hbus_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// HyperBus transaction FSM for one single-word access per request.
// Linear burst bit is left at 0 and config register writes are not done.
// Once in ERROR it stays there until rst, answering each request with err.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hbus_sequencer (
    input  logic               clk,
    input  logic               clk90,
    input  logic               rst,
    input  logic               req_valid_i,
    input  hbus_pkg::hb_req_t  req_i,
    output hbus_pkg::hb_rsp_t  rsp_o,
    output hbus_pkg::hb_word_t dq_out_o,
    output logic               dq_oe_o,
    input  hbus_pkg::hb_word_t dq_in_i,
    output hbus_pkg::hb_rwds_t rwds_out_o,
    output logic               rwds_oe_o,
    input  hbus_pkg::hb_rwds_t rwds_in_i,
    output logic               hbus_clk_o,
    output logic               hbus_csn_o,
    output logic               hbus_rstn_o
);

    import hbus_pkg::*;

    hb_state_t              state;
    logic [CNT_WIDTH-1:0]   count;
    logic [HB_CA_WIDTH-1:0] ca;
    hb_word_t               rdata_q;
    logic                   done_q;
    logic                   error_q;
    logic                   accept;
    logic                   active;
    logic                   active_q;
    logic                   clk_en90;
    logic                   strobe;
    logic                   write_beat;

    assign accept = (state == IDLE) && (count == '0) && req_valid_i;
    assign active = state inside {COMMAND, LATENCY, READ, WRITE};

    // Any RWDS activity in READ ends the access
    assign strobe = (rwds_in_i != 2'b00);

    // Data goes out on the first of the two write clocks only
    assign write_beat = (state == WRITE) && (count == CNT_WIDTH'(1));

    always_comb begin
        if (write_beat) begin
            dq_out_o = req_i.wdata;
        end else begin
            dq_out_o = ca[HB_CA_WIDTH-1 -: HB_WORD_WIDTH];
        end
    end

    assign dq_oe_o    = (state == COMMAND) || write_beat;
    assign rwds_out_o = write_beat ? req_i.mask : 2'b00;
    assign rwds_oe_o  = write_beat;

    assign rsp_o = '{done: done_q, error: error_q, rdata: rdata_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= RESET;
            count   <= CNT_WIDTH'(RESET_COUNT);
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            error_q <= 1'b0;

            case (state)
                RESET: begin
                    if (count == '0) begin
                        state <= IDLE;
                        count <= CNT_WIDTH'(CS_IDLE_COUNT);
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                IDLE: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end else if (accept) begin
                        // 48 bits at 16 per clock
                        state <= COMMAND;
                        count <= CNT_WIDTH'(2);
                    end
                end

                COMMAND: begin
                    if (count == '0) begin
                        // Device raises RWDS during CA when it wants 2x latency
                        if (rwds_in_i == 2'b11) begin
                            count <= CNT_WIDTH'(2 * TACC_COUNT - 1);
                        end else begin
                            count <= CNT_WIDTH'(TACC_COUNT - 1);
                        end
                        state <= LATENCY;
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                LATENCY: begin
                    if (count == '0) begin
                        if (req_i.write) begin
                            state <= WRITE;
                            count <= CNT_WIDTH'(1);
                        end else begin
                            state <= READ;
                            count <= CNT_WIDTH'(READ_TIMEOUT - 1);
                        end
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                READ: begin
                    if (strobe) begin
                        state  <= IDLE;
                        count  <= CNT_WIDTH'(CS_IDLE_COUNT);
                        done_q <= 1'b1;
                    end else if (count == '0) begin
                        state   <= ERROR;
                        error_q <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                WRITE: begin
                    if (count == '0) begin
                        state  <= IDLE;
                        count  <= CNT_WIDTH'(CS_IDLE_COUNT);
                        done_q <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                ERROR: begin
                    // One err pulse per request, slave drops valid after it
                    if (req_valid_i && !error_q) begin
                        error_q <= 1'b1;
                    end
                end

                default: begin
                    state <= RESET;
                    count <= CNT_WIDTH'(RESET_COUNT);
                end
            endcase
        end
    end

    // CA word: R/W#, address space, burst type, upper and lower address
    always_ff @(posedge clk) begin
        if (accept) begin
            ca <= {~req_i.write, req_i.reg_space, 1'b0,
                   1'b0, req_i.addr[30:3], 13'd0, req_i.addr[2:0]};
        end else if (state == COMMAND) begin
            ca <= ca << HB_WORD_WIDTH;
        end
    end

    // RWDS reads 01 on a valid strobe, other patterns carry no data
    always_ff @(posedge clk) begin
        if ((state == READ) && (rwds_in_i == 2'b01)) begin
            rdata_q <= dq_in_i;
        end
    end

    // Delayed one clock so csn and the clock line up with the DDR output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
        end else begin
            active_q <= active;
        end
    end

    // Re-registered on clk90 so the gated clock never starts with a half pulse
    always_ff @(posedge clk90 or posedge rst) begin
        if (rst) begin
            clk_en90 <= 1'b0;
        end else begin
            clk_en90 <= active_q;
        end
    end

    assign hbus_clk_o  = clk90 & clk_en90;
    assign hbus_csn_o  = ~active_q;
    assign hbus_rstn_o = (state != RESET);

endmodule

/* design/hbus_top.sv */
////////////////////////////////////////////////////////////////////////////
// HyperBus controller for one HyperRAM behind a Wishbone classic port.
// clk90 must lag clk by a quarter period; hbus_clk is derived from it.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hbus_top (
    input  logic               clk,
    input  logic               clk90,
    input  logic               rst,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  logic [31:0]        wb_adr_i,
    input  hbus_pkg::hb_word_t wb_dat_i,
    input  logic [1:0]         wb_sel_i,
    output hbus_pkg::hb_word_t wb_dat_o,
    output logic               wb_ack_o,
    output logic               wb_err_o,
    output logic               hbus_clk_o,
    output logic               hbus_csn_o,
    output logic               hbus_rstn_o,
    inout  wire [7:0]          hbus_dq_io,
    inout  wire                hbus_rwds_io
);

    import hbus_pkg::*;

    logic     req_valid;
    hb_req_t  req;
    hb_rsp_t  rsp;
    hb_word_t dq_out;
    hb_word_t dq_in;
    logic     dq_oe;
    hb_rwds_t rwds_out;
    hb_rwds_t rwds_in;
    logic     rwds_oe;

    hbus_wb_slave i_wb_slave (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .rsp_i       (rsp),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .wb_err_o    (wb_err_o),
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    hbus_sequencer i_sequencer (
        .clk         (clk),
        .clk90       (clk90),
        .rst         (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_o       (rsp),
        .dq_out_o    (dq_out),
        .dq_oe_o     (dq_oe),
        .dq_in_i     (dq_in),
        .rwds_out_o  (rwds_out),
        .rwds_oe_o   (rwds_oe),
        .rwds_in_i   (rwds_in),
        .hbus_clk_o  (hbus_clk_o),
        .hbus_csn_o  (hbus_csn_o),
        .hbus_rstn_o (hbus_rstn_o)
    );

    hbus_ddr_io #(.word_t(hb_word_t)) i_ddr_dq (
        .clk    (clk),
        .rst    (rst),
        .dat_i  (dq_out),
        .dat_o  (dq_in),
        .oe_i   (dq_oe),
        .pad_io (hbus_dq_io)
    );

    hbus_ddr_io #(.word_t(hb_rwds_t)) i_ddr_rwds (
        .clk    (clk),
        .rst    (rst),
        .dat_i  (rwds_out),
        .dat_o  (rwds_in),
        .oe_i   (rwds_oe),
        .pad_io (hbus_rwds_io)
    );

endmodule

/* design/hbus_wb_slave.sv */
////////////////////////////////////////////////////////////////////////////
// Wishbone classic slave, one 16-bit word per cycle, no bursts.
// The master must hold cyc and stb until ack or err; dropping cyc early
// does not cancel a request already handed to the sequencer.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hbus_wb_slave (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  logic [31:0]        wb_adr_i,
    input  hbus_pkg::hb_word_t wb_dat_i,
    input  logic [1:0]         wb_sel_i,
    input  hbus_pkg::hb_rsp_t  rsp_i,
    output hbus_pkg::hb_word_t wb_dat_o,
    output logic               wb_ack_o,
    output logic               wb_err_o,
    output logic               req_valid_o,
    output hbus_pkg::hb_req_t  req_o
);

    logic pending;
    logic start;
    logic rsp_seen;

    // New strobed cycle, not yet issued
    assign start = wb_cyc_i & wb_stb_i & ~pending;

    // Response only counts while a request is outstanding
    assign rsp_seen = req_valid_o & (rsp_i.done | rsp_i.error);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending     <= 1'b0;
            req_valid_o <= 1'b0;
            wb_ack_o    <= 1'b0;
            wb_err_o    <= 1'b0;
        end else begin
            wb_ack_o <= rsp_seen & ~rsp_i.error;
            wb_err_o <= rsp_seen & rsp_i.error;

            if (start) begin
                pending     <= 1'b1;
                req_valid_o <= 1'b1;
            end else begin
                if (rsp_seen) begin
                    req_valid_o <= 1'b0;
                end
                // Master still holds stb during the ack clock
                if (wb_ack_o | wb_err_o) begin
                    pending <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_o.write     <= wb_we_i;
            req_o.reg_space <= wb_adr_i[31];
            req_o.addr      <= wb_adr_i[30:0];
            req_o.wdata     <= wb_dat_i;
            // HyperBus mask is active high, sel is active high enable
            req_o.mask      <= ~wb_sel_i;
        end
        if (rsp_seen) begin
            wb_dat_o <= rsp_i.rdata;
        end
    end

endmodule
